// File: hw/boot_rom.sv
`timescale 1ns/1ps
`include "prog_consts.svh"

module boot_rom import prog_pkg::*; (
  input  logic                    sys_clk,
  input  logic                    sys_rst,
  input  logic [`BOOT_ROM_AW-1:0] addr_i,
  output byte_t                   data_o
);

  // small clear loop, clears xram from 0 upward
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      data_o <= '0;
    end else begin
      case (addr_i)
        4'h0: data_o <= 8'h02;  // ljmp 0003
        4'h1: data_o <= 8'h00;
        4'h2: data_o <= 8'h03;
        4'h3: data_o <= 8'h75;  // mov sp,#07
        4'h4: data_o <= 8'h81;
        4'h5: data_o <= 8'h07;
        4'h6: data_o <= 8'h90;  // mov dptr,#0000
        4'h7: data_o <= 8'h00;
        4'h8: data_o <= 8'h00;
        4'h9: data_o <= 8'he4;  // clr a
        4'ha: data_o <= 8'hf0;  // movx @dptr,a
        4'hb: data_o <= 8'ha3;  // inc dptr
        4'hc: data_o <= 8'h80;  // sjmp back to movx
        4'hd: data_o <= 8'hfc;
        default: data_o <= 8'h00;
      endcase
    end
  end

endmodule

// File: hw/prog_bank_sel.sv
`timescale 1ns/1ps
`include "prog_consts.svh"

module prog_bank_sel import prog_pkg::*; (
  input  logic                     sys_clk,
  input  logic                     sys_rst,
  input  logic                     cpu_hold_i,  // 1: cpu in reset, loader owns RAM
  input  ram_req_t                 ldr_req_i,
  input  prog_addr_t               cpu_addr_i,
  input  byte_t                    cpu_wdata_i,
  input  logic                     cpu_wr_i,
  input  logic                     cpu_rd_i,
  input  logic                     ram_mode_i,  // 1: code from RAM, 0: from ROM
  input  byte_t                    bank_rdata_i [`PROG_BANKS],
  input  byte_t                    rom_data_i,
  output logic [`PROG_BANKS-1:0]   bank_wr_o,
  output logic [`PROG_BANKS-1:0]   bank_rd_o,
  output logic [`PROG_BANK_AW-1:0] bank_addr_o,
  output byte_t                    bank_wdata_o,
  output byte_t                    ldr_rdata_o,
  output logic [`BOOT_ROM_AW-1:0]  rom_addr_o,
  output byte_t                    code_o
);

  ram_req_t  req;
  bank_idx_t req_bank;
  logic      req_hit;
  bank_idx_t rd_bank_q;  // bank of the last read
  logic      rd_hit_q;
  byte_t     ram_rdata;

  // owner of the RAM
  always_comb begin
    if (cpu_hold_i) begin
      req = ldr_req_i;
    end else begin
      req = '{addr: cpu_addr_i, wdata: cpu_wdata_i, wr: cpu_wr_i, rd: cpu_rd_i};
    end
  end

  assign req_bank = req.addr[`PROG_BANK_AW +: $bits(bank_idx_t)];
  assign req_hit  = (req.addr[15:`PROG_BANK_AW] < `PROG_BANKS);  // 0x4000 and up miss

  always_comb begin
    for (int i = 0; i < `PROG_BANKS; i++) begin
      bank_wr_o[i] = req.wr & req_hit & (req_bank == i);
      bank_rd_o[i] = req.rd & req_hit & (req_bank == i);
    end
  end

  assign bank_addr_o  = req.addr[`PROG_BANK_AW-1:0];
  assign bank_wdata_o = req.wdata;

  // remember where the read went so the mux follows the data
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      rd_bank_q <= '0;
      rd_hit_q  <= 1'b0;
    end else if (req.rd) begin
      rd_bank_q <= req_bank;
      rd_hit_q  <= req_hit;
    end
  end

  assign ram_rdata = rd_hit_q ? bank_rdata_i[rd_bank_q] : '0;  // zero out of range

  assign ldr_rdata_o = ram_rdata;
  assign rom_addr_o  = cpu_addr_i[`BOOT_ROM_AW-1:0];
  assign code_o      = ram_mode_i ? ram_rdata : rom_data_i;

endmodule

// File: hw/prog_consts.svh
`ifndef PROG_CONSTS_SVH
`define PROG_CONSTS_SVH

// register bus map of the loader
`define PROG_REG_ADDR_H 9'h1a
`define PROG_REG_ADDR_L 9'h1b
`define PROG_REG_DATA   9'h1c

// program RAM organisation
`define PROG_BANKS   4
`define PROG_BANK_AW 12  // 4K bytes per bank

// boot ROM, 16 entries
`define BOOT_ROM_AW 4

`endif

// File: hw/prog_loader.sv
`timescale 1ns/1ps
`include "prog_consts.svh"

module prog_loader import prog_pkg::*; (
  input  logic      sys_clk,
  input  logic      sys_rst,
  input  logic      prog_mode_i,  // 0 sequential write, 1 sequential read
  input  logic      rab_write_i,
  input  logic      rab_read_i,
  input  rab_addr_t rab_addr_i,
  input  byte_t     rab_wdata_i,
  output byte_t     rab_rdata_o,
  output logic      rab_ack_o,
  input  byte_t     ram_rdata_i,
  output ram_req_t  ram_req_o
);

  byte_t      addr_h_q;
  byte_t      addr_l_q;
  byte_t      data_q;      // data register, write byte or prefetched read byte
  prog_addr_t ram_addr_q;  // running RAM address
  loader_st_e state_q;
  logic       wr_pend_q;
  logic       wr_q;
  logic       rd_q;
  logic       rd_d_q;      // RAM data valid this cycle

  logic sel_h;
  logic sel_l;
  logic sel_d;
  logic reg_hit;
  logic addr_h_wr;
  logic addr_l_wr;
  logic data_wr;
  logic data_rd;
  logic wr_state;

  assign sel_h   = (rab_addr_i == `PROG_REG_ADDR_H);
  assign sel_l   = (rab_addr_i == `PROG_REG_ADDR_L);
  assign sel_d   = (rab_addr_i == `PROG_REG_DATA);
  assign reg_hit = sel_h | sel_l | sel_d;

  assign addr_h_wr = rab_write_i & sel_h;
  assign addr_l_wr = rab_write_i & sel_l;
  assign data_wr   = rab_write_i & sel_d & ~prog_mode_i;  // store only in write mode
  assign data_rd   = rab_read_i & sel_d;
  assign wr_state  = (state_q == LD_WRITE_FIRST) || (state_q == LD_WRITE_NEXT);

  // ack one cycle after any strobe to our three registers
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      rab_ack_o <= 1'b0;
    end else begin
      rab_ack_o <= (rab_write_i | rab_read_i) & reg_hit;
    end
  end

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      rab_rdata_o <= '0;
    end else if (rab_read_i) begin
      if (sel_h) rab_rdata_o <= addr_h_q;
      else if (sel_l) rab_rdata_o <= addr_l_q;
      else if (sel_d) rab_rdata_o <= data_q;  // byte fetched ahead
      else rab_rdata_o <= '0;
    end
  end

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      addr_h_q <= '0;
      addr_l_q <= '0;
    end else begin
      if (addr_h_wr) addr_h_q <= rab_wdata_i;
      if (addr_l_wr) addr_l_q <= rab_wdata_i;
    end
  end

  // writing the low address arms a transfer, high address starts over
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      state_q <= LD_IDLE;
    end else if (addr_h_wr) begin
      state_q <= LD_IDLE;
    end else if (addr_l_wr) begin
      state_q <= prog_mode_i ? LD_READ : LD_WRITE_FIRST;
    end else if (data_wr && state_q == LD_WRITE_FIRST) begin
      state_q <= LD_WRITE_NEXT;
    end
  end

  // running address is ready before the RAM pulse
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      ram_addr_q <= '0;
    end else if (addr_l_wr && prog_mode_i) begin
      ram_addr_q <= {addr_h_q, rab_wdata_i};  // new low byte, not the old one
    end else if (data_wr && state_q == LD_WRITE_FIRST) begin
      ram_addr_q <= {addr_h_q, addr_l_q};
    end else if (data_wr && state_q == LD_WRITE_NEXT) begin
      ram_addr_q <= ram_addr_q + 16'd1;
    end else if (data_rd && prog_mode_i && state_q == LD_READ) begin
      ram_addr_q <= ram_addr_q + 16'd1;
    end
  end

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      data_q <= '0;
    end else if (data_wr) begin
      data_q <= rab_wdata_i;
    end else if (rd_d_q) begin
      data_q <= ram_rdata_i;  // prefetched byte
    end
  end

  // write pulse two cycles after the data strobe, read pulse one cycle after
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      wr_pend_q <= 1'b0;
      wr_q      <= 1'b0;
      rd_q      <= 1'b0;
      rd_d_q    <= 1'b0;
    end else begin
      wr_pend_q <= data_wr & wr_state;
      wr_q      <= wr_pend_q;
      rd_q      <= prog_mode_i & (addr_l_wr | (data_rd & (state_q == LD_READ)));
      rd_d_q    <= rd_q;
    end
  end

  assign ram_req_o = '{addr: ram_addr_q, wdata: data_q, wr: wr_q, rd: rd_q};

endmodule

// File: hw/prog_mem_top.sv
`timescale 1ns/1ps
`include "prog_consts.svh"

module prog_mem_top import prog_pkg::*; (
  input  logic       sys_clk,
  input  logic       sys_rst,
  input  logic       prog_mode_i,
  input  logic       rab_write_i,
  input  logic       rab_read_i,
  input  rab_addr_t  rab_addr_i,
  input  byte_t      rab_wdata_i,
  output byte_t      rab_rdata_o,
  output logic       rab_ack_o,
  input  logic       cpu_hold_i,
  input  prog_addr_t cpu_addr_i,
  input  byte_t      cpu_wdata_i,
  input  logic       cpu_wr_i,
  input  logic       cpu_rd_i,
  input  logic       ram_mode_i,
  output byte_t      code_o
);

  ram_req_t                 ldr_req;
  byte_t                    ldr_rdata;
  logic [`PROG_BANKS-1:0]   bank_wr;
  logic [`PROG_BANKS-1:0]   bank_rd;
  logic [`PROG_BANK_AW-1:0] bank_addr;
  byte_t                    bank_wdata;
  byte_t                    bank_rdata [`PROG_BANKS];
  logic [`BOOT_ROM_AW-1:0]  rom_addr;
  byte_t                    rom_data;

  prog_loader u_loader (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .prog_mode_i (prog_mode_i),
    .rab_write_i (rab_write_i),
    .rab_read_i  (rab_read_i),
    .rab_addr_i  (rab_addr_i),
    .rab_wdata_i (rab_wdata_i),
    .rab_rdata_o (rab_rdata_o),
    .rab_ack_o   (rab_ack_o),
    .ram_rdata_i (ldr_rdata),
    .ram_req_o   (ldr_req)
  );

  prog_bank_sel u_bank_sel (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .cpu_hold_i   (cpu_hold_i),
    .ldr_req_i    (ldr_req),
    .cpu_addr_i   (cpu_addr_i),
    .cpu_wdata_i  (cpu_wdata_i),
    .cpu_wr_i     (cpu_wr_i),
    .cpu_rd_i     (cpu_rd_i),
    .ram_mode_i   (ram_mode_i),
    .bank_rdata_i (bank_rdata),
    .rom_data_i   (rom_data),
    .bank_wr_o    (bank_wr),
    .bank_rd_o    (bank_rd),
    .bank_addr_o  (bank_addr),
    .bank_wdata_o (bank_wdata),
    .ldr_rdata_o  (ldr_rdata),
    .rom_addr_o   (rom_addr),
    .code_o       (code_o)
  );

  // four 4 KB banks share address and write data
  for (genvar i = 0; i < `PROG_BANKS; i++) begin : g_bank
    prog_ram_bank u_bank (
      .sys_clk (sys_clk),
      .wr_i    (bank_wr[i]),
      .rd_i    (bank_rd[i]),
      .addr_i  (bank_addr),
      .wdata_i (bank_wdata),
      .rdata_o (bank_rdata[i])
    );
  end

  boot_rom u_rom (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst),
    .addr_i  (rom_addr),
    .data_o  (rom_data)
  );

endmodule

// File: hw/prog_pkg.sv
package prog_pkg;

  // 8051 program space address
  typedef logic [15:0] prog_addr_t;

  typedef logic [7:0] byte_t;

  // register bus address from the i2c slave
  typedef logic [8:0] rab_addr_t;

  // one of the four 4 KB banks
  typedef logic [1:0] bank_idx_t;

  // one RAM access, wr and rd are single-cycle pulses
  typedef struct packed {
    prog_addr_t addr;
    byte_t      wdata;
    logic       wr;
    logic       rd;
  } ram_req_t;

  // loader sequencing
  // write mode picks start address on the first data byte, then counts up
  typedef enum logic [1:0] {
    LD_IDLE        = 2'd0,
    LD_WRITE_FIRST = 2'd1,  // start address set, no byte stored yet
    LD_WRITE_NEXT  = 2'd2,  // running address in use
    LD_READ        = 2'd3   // sequential readback with prefetch
  } loader_st_e;

endpackage

// File: hw/prog_ram_bank.sv
`timescale 1ns/1ps
`include "prog_consts.svh"

module prog_ram_bank import prog_pkg::*; (
  input  logic                     sys_clk,
  input  logic                     wr_i,
  input  logic                     rd_i,
  input  logic [`PROG_BANK_AW-1:0] addr_i,
  input  byte_t                    wdata_i,
  output byte_t                    rdata_o
);

  localparam int DEPTH = 1 << `PROG_BANK_AW;

  byte_t mem [DEPTH];

  always_ff @(posedge sys_clk) begin
    if (wr_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // output holds until the next read
  always_ff @(posedge sys_clk) begin
    if (rd_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

// File: list.f
+incdir+hw
hw/prog_pkg.sv
hw/prog_ram_bank.sv
hw/boot_rom.sv
hw/prog_loader.sv
hw/prog_bank_sel.sv
hw/prog_mem_top.sv
sim/prog_mem_checker.sv
sim/prog_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module prog_mem_tb -f list.f -o Vprog_mem_tb

# let assertion errors accumulate so the testbench still prints its summary
./obj_dir/Vprog_mem_tb +verilator+error+limit+1000 | tee sim.log

if grep -q '>>> FAIL' sim.log; then
  exit 1
fi
grep -q '>>> PASS' sim.log

// File: sim/prog_mem_checker.sv
`timescale 1ns/1ps

module prog_mem_checker import prog_pkg::*; (
  input logic       sys_clk,
  input logic       sys_rst,
  input logic       prog_mode_i,
  input logic       rab_ack_i,
  input ram_req_t   ram_req_i,
  input loader_st_e state_i
);

  int unsigned viol_cnt = 0;  // failed assertions so far

  // one RAM access at a time
  a_no_wr_rd: assert property (@(posedge sys_clk) disable iff (sys_rst)
    !(ram_req_i.wr && ram_req_i.rd))
    else begin
      $error("RAM write and read pulse in the same cycle");
      viol_cnt++;
    end

  a_ack_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
    rab_ack_i |=> !rab_ack_i)  // ack is a one-cycle pulse
    else begin
      $error("register bus ack high for two cycles in a row");
      viol_cnt++;
    end

  // idle write mode has nothing to store or fetch
  a_idle_quiet: assert property (@(posedge sys_clk) disable iff (sys_rst)
    !((state_i == LD_IDLE) && !prog_mode_i && (ram_req_i.wr || ram_req_i.rd)))
    else begin
      $error("RAM pulse while the loader is idle in write mode");
      viol_cnt++;
    end

endmodule

// File: sim/prog_mem_tb.sv
`timescale 1ns/1ps
`include "prog_consts.svh"

module prog_mem_tb import prog_pkg::*; ();

  localparam int N_ACK    = 40;
  localparam int N_REG    = 16;
  localparam int N_BURST  = 12;
  localparam int MAX_LEN  = 16;
  localparam int N_CPU    = 24;
  localparam int N_ROM    = 20;
  localparam int ACK_WAIT = 4;
  // strobes and cpu steps over all tests
  localparam int TEST_LEN = N_ACK + 4 * N_REG + N_BURST * (2 * MAX_LEN + 4)
                          + 3 * N_CPU + 3 * N_ROM;

  logic       sys_clk;
  logic       sys_rst;
  logic       prog_mode_i;
  logic       rab_write_i;
  logic       rab_read_i;
  rab_addr_t  rab_addr_i;
  byte_t      rab_wdata_i;
  byte_t      rab_rdata_o;
  logic       rab_ack_o;
  logic       cpu_hold_i;
  prog_addr_t cpu_addr_i;
  byte_t      cpu_wdata_i;
  logic       cpu_wr_i;
  logic       cpu_rd_i;
  logic       ram_mode_i;
  byte_t      code_o;

  byte_t       model_mem [16384];  // the four banks as one flat array
  prog_addr_t  loaded_q [$];
  byte_t       rom_table [16] = '{8'h02, 8'h00, 8'h03, 8'h75, 8'h81, 8'h07, 8'h90, 8'h00,
                                  8'h00, 8'he4, 8'hf0, 8'ha3, 8'h80, 8'hfc, 8'h00, 8'h00};
  logic [31:0] lcg_state = 32'he187_4a6e;
  int          chk_cnt = 0;
  int          err_cnt = 0;
  int          mark_chk = 0;
  int          mark_err = 0;

  prog_mem_top DUT (.*);

  // loader exists once, as DUT.u_loader
  bind prog_loader prog_mem_checker u_checker (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .prog_mode_i (prog_mode_i),
    .rab_ack_i   (rab_ack_o),
    .ram_req_i   (ram_req_o),
    .state_i     (state_q)
  );

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  initial begin
    repeat (TEST_LEN * 8) @(posedge sys_clk);
    $display("watchdog expired after %0d cycles, tests did not complete", TEST_LEN * 8);
    $display(">>> FAIL");
    $finish;
  end

  function automatic int unsigned rand_below(input int unsigned n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state >> 8) % n;  // low bits of an lcg repeat quickly
  endfunction

  task automatic check_byte(input string sig, input byte_t got, input byte_t exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("Fail %s got 0x%02h exp 0x%02h at %0t", sig, got, exp, $time);
      err_cnt++;
    end
  endtask

  // one strobe, then poll for the ack
  task automatic rab_access(input logic wr, input rab_addr_t addr, input byte_t wdata,
                            input logic ack_exp, output byte_t rdata);
    int waited;
    @(negedge sys_clk);
    rab_write_i = wr;
    rab_read_i  = ~wr;
    rab_addr_i  = addr;
    rab_wdata_i = wdata;
    @(negedge sys_clk);
    rab_write_i = 1'b0;
    rab_read_i  = 1'b0;
    waited = 1;
    while (!rab_ack_o && waited < ACK_WAIT) begin
      @(negedge sys_clk);
      waited++;
    end
    rdata = rab_rdata_o;
    chk_cnt++;
    if (ack_exp) begin
      assert (rab_ack_o && waited == 1) else begin
        $display("no ack one cycle after the strobe to register 0x%03h", addr);
        err_cnt++;
      end
      repeat (2) @(negedge sys_clk);  // four cycles between strobes
    end else begin
      assert (!rab_ack_o) else begin
        $display("Fail rab_ack_o got 0x1 exp 0x0 for address 0x%03h", addr);
        err_cnt++;
      end
    end
  endtask

  task automatic reg_write(input rab_addr_t addr, input byte_t data);
    byte_t unused;
    rab_access(1'b1, addr, data, 1'b1, unused);
  endtask

  task automatic reg_read(input rab_addr_t addr, output byte_t data);
    rab_access(1'b0, addr, 8'h00, 1'b1, data);
  endtask

  task automatic set_start(input logic mode, input prog_addr_t addr);
    @(negedge sys_clk);
    prog_mode_i = mode;
    reg_write(`PROG_REG_ADDR_H, addr[15:8]);
    reg_write(`PROG_REG_ADDR_L, addr[7:0]);
  endtask

  task automatic cpu_read(input prog_addr_t addr, output byte_t code);
    @(negedge sys_clk);
    cpu_addr_i = addr;
    cpu_rd_i   = 1'b1;
    @(negedge sys_clk);
    cpu_rd_i = 1'b0;
    code     = code_o;
  endtask

  task automatic cpu_write(input prog_addr_t addr, input byte_t data);
    @(negedge sys_clk);
    cpu_addr_i  = addr;
    cpu_wdata_i = data;
    cpu_wr_i    = 1'b1;
    @(negedge sys_clk);
    cpu_wr_i = 1'b0;
    if (addr < 16'h4000) begin
      model_mem[addr[13:0]] = data;
      loaded_q.push_back(addr);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, chk_cnt - mark_chk, err_cnt - mark_err);
    mark_chk = chk_cnt;
    mark_err = err_cnt;
  endtask

  initial begin
    byte_t       got;
    byte_t       data;
    rab_addr_t   addr;
    prog_addr_t  start;
    prog_addr_t  la;
    int          len;
    logic        hit;
    int unsigned viol;
    sys_rst     = 1'b1;
    prog_mode_i = 1'b1;
    rab_write_i = 1'b0;
    rab_read_i  = 1'b0;
    rab_addr_i  = '0;
    rab_wdata_i = '0;
    cpu_hold_i  = 1'b1;
    cpu_addr_i  = '0;
    cpu_wdata_i = '0;
    cpu_wr_i    = 1'b0;
    cpu_rd_i    = 1'b0;
    ram_mode_i  = 1'b0;
    repeat (4) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst = 1'b0;

    // read mode, so stray data writes never reach the RAM
    for (int i = 0; i < N_ACK; i++) begin
      addr = rand_below(2) ? rab_addr_t'(9'h1a + rand_below(3)) : rab_addr_t'(rand_below(512));
      hit  = (addr >= `PROG_REG_ADDR_H) && (addr <= `PROG_REG_DATA);
      rab_access(rand_below(2) == 1, addr, byte_t'(rand_below(256)), hit, got);
    end
    finish_test("ack rule");

    for (int i = 0; i < N_REG; i++) begin
      start = prog_addr_t'(rand_below(65536));
      reg_write(`PROG_REG_ADDR_H, start[15:8]);
      reg_write(`PROG_REG_ADDR_L, start[7:0]);
      reg_read(`PROG_REG_ADDR_H, got);
      check_byte("rab_rdata_o", got, start[15:8]);
      reg_read(`PROG_REG_ADDR_L, got);
      check_byte("rab_rdata_o", got, start[7:0]);
    end
    finish_test("address registers");

    for (int b = 0; b < N_BURST; b++) begin
      len = 2 + rand_below(MAX_LEN - 1);
      if (b % 3 == 0) begin  // ends past a bank boundary
        start = prog_addr_t'((1 + rand_below(3)) * 4096 - 1 - rand_below(len - 1));
      end else begin
        start = prog_addr_t'(rand_below(16384 - len));
      end
      set_start(1'b0, start);
      for (int i = 0; i < len; i++) begin
        data = byte_t'(rand_below(256));
        reg_write(`PROG_REG_DATA, data);
        model_mem[int'(start) + i] = data;
        loaded_q.push_back(prog_addr_t'(int'(start) + i));
      end
      set_start(1'b1, start);
      for (int i = 0; i < len; i++) begin
        reg_read(`PROG_REG_DATA, got);
        check_byte("rab_rdata_o", got, model_mem[int'(start) + i]);
      end
    end
    finish_test("sequential write and read");

    @(negedge sys_clk);
    cpu_hold_i = 1'b0;
    ram_mode_i = 1'b1;
    for (int i = 0; i < N_CPU; i++) begin
      la = loaded_q[rand_below(loaded_q.size())];
      cpu_read(la, got);
      check_byte("code_o", got, model_mem[la[13:0]]);
      la = prog_addr_t'(rand_below(16384));
      cpu_write(la, byte_t'(rand_below(256)));
      cpu_read(la, got);
      check_byte("code_o", got, model_mem[la[13:0]]);
    end
    finish_test("cpu access");

    ram_mode_i = 1'b0;
    for (int i = 0; i < N_ROM; i++) begin
      la = prog_addr_t'(rand_below(65536));
      @(negedge sys_clk);
      cpu_addr_i = la;
      @(negedge sys_clk);
      check_byte("code_o", code_o, rom_table[la[3:0]]);
    end
    ram_mode_i = 1'b1;
    for (int i = 0; i < N_ROM / 2; i++) begin
      cpu_read(prog_addr_t'(16'h4000 + rand_below(16'hc000)), got);
      check_byte("code_o", got, 8'h00);
      la = loaded_q[rand_below(loaded_q.size())];
      cpu_write({2'(1 + rand_below(3)), la[13:0]}, ~model_mem[la[13:0]]);  // aliases la
      cpu_read(la, got);
      check_byte("code_o", got, model_mem[la[13:0]]);
    end
    finish_test("rom and range");

    viol = DUT.u_loader.u_checker.viol_cnt;
    $display("total: %0d checks, %0d errors, %0d assertion failures", chk_cnt, err_cnt, viol);
    if (err_cnt == 0 && viol == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
